/* bench/idct_props.sv */
// *************************************************************************
// concurrent checks on the reading level and the done pulse, bound to idct
// *************************************************************************
`timescale 1ns/1ps

module idctProps (
   input logic clk,
   input logic racc,
   input logic reading,
   input logic done
);
   // consecutive cycles with reading high
   logic [6:0] readLen;

   always_ff @(posedge clk or posedge racc)
   begin
      if (racc)
         readLen <= '0;
      else if (reading)
         readLen <= readLen + 7'd1;
      else
         readLen <= '0;
   end

   readMax: assert property (@(posedge clk) disable iff (racc) reading |-> readLen < 7'd64)
      else $error("reading high for more than 64 cycles");

   // a load that ended must have lasted the whole block
   readFull: assert property (@(posedge clk) disable iff (racc)
      (!reading && readLen != 7'd0) |-> readLen == 7'd64)
      else $error("reading dropped before 64 cycles");

   donePulse: assert property (@(posedge clk) disable iff (racc) done |=> !done)
      else $error("done held for more than one cycle");

   notBoth: assert property (@(posedge clk) disable iff (racc) !(reading && done))
      else $error("reading and done high together");

   resetQuiet: assert property (@(posedge clk) racc |-> (!reading && !done))
      else $error("control outputs active during reset");

endmodule

bind idct idctProps props (.clk(clk), .racc(racc), .reading(reading), .done(done));

/* bench/idct_tb.sv */
// *************************************************************************
// table-driven testbench for the 8x8 transform: reference model, clock,
// reset, watchdog and the run report
// *************************************************************************
`timescale 1ns/1ps
`include "idct_config.svh"

module idctTb;

   typedef enum logic [1:0] {Impulse, Ramp, RandomBlk} patternT;
   typedef struct packed {
      patternT kind;
      logic apx;
      logic midStart;
   } stimRowT;

   localparam int NumRows = 6;
   localparam int CycleLimit = NumRows * 1400;

   // same three blocks in accurate and then approximate mode
   stimRowT stimTab [NumRows] = '{
      '{Impulse,   1'b0, 1'b0},
      '{Ramp,      1'b0, 1'b0},
      '{RandomBlk, 1'b0, 1'b1},
      '{Impulse,   1'b1, 1'b0},
      '{Ramp,      1'b1, 1'b1},
      '{RandomBlk, 1'b1, 1'b0}
   };

   logic clk, racc, start, rapx;
   logic [31:0] din;
   logic reading, done;
   logic [31:0] dout;

   int coefTab [8][8];
   int randData [64];
   int inData [64];
   int expOut [64];
   int cycleCount = 0;
   int failedChecks = 0;
   int passedTests = 0;
   int failedTests = 0;

   idct idct_i (
      .clk     (clk),
      .racc    (racc),
      .start   (start),
      .rapx    (rapx),
      .din     (din),
      .reading (reading),
      .done    (done),
      .dout    (dout)
   );

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   always @(posedge clk)
      cycleCount <= cycleCount + 1;

   initial
   begin
      wait (cycleCount >= CycleLimit);
      $display("timeout: the run did not finish within %0d cycles", CycleLimit);
      $display("ERRORS FOUND");
      $finish;
   end

   // cosine coefficients rounded from the defining formula
   task automatic buildCoefs();
      real s;
      real r;
      for (int u = 0; u < 8; u++)
      begin
         for (int x = 0; x < 8; x++)
         begin
            s = (u == 0) ? $sqrt(0.125) : 0.5;
            r = 32768.0 * s * $cos((2 * x + 1) * u * 3.14159265358979 / 16.0);
            coefTab[u][x] = (r >= 0.0) ? $rtoi(r + 0.5) : -$rtoi(0.5 - r);
         end
      end
   endtask

   // one scaled product of two 24-bit operands
   function automatic int scaledProduct(int a, int b, int cutA, int cutB, bit apx);
      int opA;
      int opB;
      longint prod;
      opA = (a <<< 8) >>> 8;
      opB = (b <<< 8) >>> 8;
      if (apx)
      begin
         opA = opA & ~((1 << cutA) - 1);
         opB = opB & ~((1 << cutB) - 1);
      end
      prod = longint'(opA) * longint'(opB);
      return int'(prod >>> `IDCT_PROD_SHIFT);
   endfunction

   task automatic computeExpected(bit apx);
      int tmp [8][8];
      int acc;
      for (int j = 0; j < 8; j++)
      begin
         for (int i = 0; i < 8; i++)
         begin
            acc = 0;
            for (int k = 0; k < 8; k++)
               acc += scaledProduct(inData[j * 8 + k], coefTab[i][k],
                                    `IDCT_P1_CUT_A, `IDCT_P1_CUT_B, apx);
            tmp[j][i] = acc;
         end
      end
      // column pass takes bits 31:8 of the intermediate
      for (int j = 0; j < 8; j++)
      begin
         for (int i = 0; i < 8; i++)
         begin
            acc = 0;
            for (int k = 0; k < 8; k++)
               acc += scaledProduct(tmp[k][i] >>> `IDCT_P2_SRC_LSB, coefTab[j][k],
                                    `IDCT_P2_CUT_A, `IDCT_P2_CUT_B, apx);
            expOut[j * 8 + i] = acc;
         end
      end
   endtask

   task automatic fillPattern(patternT kind);
      for (int n = 0; n < 64; n++)
      begin
         case (kind)
            Impulse:   inData[n] = (n == 18) ? 16384 : 0;
            Ramp:      inData[n] = n * 250 - 8000;
            default:   inData[n] = randData[n];
         endcase
      end
   endtask

   task automatic runBlock(int idx);
      stimRowT r;
      int errs;
      int waitCycles;
      r = stimTab[idx];
      errs = 0;
      fillPattern(r.kind);
      computeExpected(r.apx);

      @(negedge clk);
      if (reading || done)
      begin
         $display("block %0d: DUT was not idle before start", idx);
         errs++;
      end
      rapx = r.apx;
      start = 1'b1;

      // din for element n goes out on the falling edge before its capture
      for (int n = 0; n < 64; n++)
      begin
         @(negedge clk);
         start = 1'b0;
         if (!reading)
         begin
            $display("block %0d: reading low at load element %0d, time %0t", idx, n, $time);
            errs++;
         end
         din = inData[n];
      end
      @(negedge clk);
      if (reading)
      begin
         $display("block %0d: reading still high after 64 cycles", idx);
         errs++;
      end

      // compute; a stray start half way must change nothing
      waitCycles = 0;
      while (!done)
      begin
         if (reading)
         begin
            $display("block %0d: reading raised again during compute", idx);
            errs++;
         end
         start = r.midStart && (waitCycles == 300);
         @(negedge clk);
         waitCycles++;
      end
      start = 1'b0;

      for (int n = 0; n < 64; n++)
      begin
         @(negedge clk);
         if (done || reading)
         begin
            $display("block %0d: done or reading high while streaming", idx);
            errs++;
         end
         if (dout !== 32'(expOut[n]))
         begin
            $display("mismatch at %0t: block %0d dout[%0d] = %0d, expected %0d",
                     $time, idx, n, $signed(dout), expOut[n]);
            errs++;
         end
      end

      // no second done or reload while dout holds element 63
      repeat (2)
      begin
         @(negedge clk);
         if (done || reading)
         begin
            $display("block %0d: extra done or reading after the stream", idx);
            errs++;
         end
         if (dout !== 32'(expOut[63]))
         begin
            $display("mismatch at %0t: block %0d dout after stream = %0d, expected %0d",
                     $time, idx, $signed(dout), expOut[63]);
            errs++;
         end
      end

      $display("block %0d (%s, rapx %0d, restart pulse %0d): %s", idx, r.kind.name(),
               r.apx, r.midStart, (errs == 0) ? "ok" : "failed");
      failedChecks += errs;
      if (errs == 0)
         passedTests++;
      else
         failedTests++;
   endtask

   initial
   begin
      racc = 1'b1;
      start = 1'b0;
      rapx = 1'b0;
      din = '0;
      void'($urandom(95));
      buildCoefs();
      for (int n = 0; n < 64; n++)
         randData[n] = int'($urandom % 32769) - 16384;

      repeat (2) @(posedge clk);
      @(negedge clk);
      racc = 1'b0;
      @(negedge clk);
      if (reading !== 1'b0 || done !== 1'b0 || dout !== 32'd0)
      begin
         $display("mismatch at %0t: after reset reading %b done %b dout %0h",
                  $time, reading, done, dout);
         failedChecks++;
         failedTests++;
         $display("reset: failed");
      end
      else
      begin
         passedTests++;
         $display("reset: ok");
      end

      for (int i = 0; i < NumRows; i++)
         runBlock(i);

      $display("tests %0d, passed %0d, failed %0d, failed checks %0d",
               passedTests + failedTests, passedTests, failedTests, failedChecks);
      if (failedChecks == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

endmodule

/* build.f */
+incdir+common
common/idct_pkg.sv
common/idct_mac_if.sv
design/idctCoefRom.sv
design/idctSequencer.sv
design/idctBlockStore.sv
mac/idctMac.sv
design/idct.sv
bench/idct_props.sv
bench/idct_tb.sv

/* common/idct_config.svh */
// *************************************************************************
// widths, approximate-mode cut widths, product scaling and MAC depth
// for the 8x8 two-pass block transform
// *************************************************************************
`ifndef IDCT_CONFIG_SVH
`define IDCT_CONFIG_SVH

// sample and accumulator width
`define IDCT_DATA_W      32
// multiplier operand width
`define IDCT_OPND_W      24
// low product bits dropped after the multiply
`define IDCT_PROD_SHIFT  16
// column pass takes intermediate bits 31:8
`define IDCT_P2_SRC_LSB  8

// cleared operand LSBs in approximate mode, per pass
`define IDCT_P1_CUT_A    0
`define IDCT_P1_CUT_B    4
`define IDCT_P2_CUT_A    4
`define IDCT_P2_CUT_B    4

`define IDCT_MAC_DEPTH   2
`define IDCT_BLOCK_N     8

`endif

/* common/idct_mac_if.sv */
// *************************************************************************
// operand and result bus between the block store and the shared MAC
// *************************************************************************
`timescale 1ns/1ps

interface idctMacIf;
   import idctPkg::*;

   // store to MAC
   logic issue;
   operandT opA;
   operandT opB;
   logic colPass;
   logic lastTerm;
   // {row, outer} of the element being summed
   logic [5:0] dstIdx;

   // MAC to store
   logic resultValid;
   sampleT result;
   logic [5:0] resultIdx;
   logic resultCol;

   modport store (output issue, opA, opB, colPass, lastTerm, dstIdx,
                  input resultValid, result, resultIdx, resultCol);
   modport mac (input issue, opA, opB, colPass, lastTerm, dstIdx,
                output resultValid, result, resultIdx, resultCol);
endinterface

/* common/idct_pkg.sv */
// *************************************************************************
// shared types of the block transform: samples, operands, phases
// and the element index word
// *************************************************************************
`include "idct_config.svh"

package idctPkg;

   typedef logic signed [`IDCT_DATA_W-1:0] sampleT;
   typedef logic signed [`IDCT_OPND_W-1:0] operandT;

   typedef enum logic [2:0] {
      Idle,
      Load,
      RowPass,
      RowFlush,
      ColPass,
      ColFlush,
      Finish,
      Stream
   } phaseT;

   // outer = output column, row = output row, term = summation index
   typedef struct packed {
      logic [2:0] outer;
      logic [2:0] row;
      logic [2:0] term;
   } elemFieldsT;

   // one counter word, seen either as a plain count or as its fields
   typedef union packed {
      logic [8:0] lin;
      elemFieldsT f;
   } elemIdxU;

endpackage

/* design/idct.sv */
// *************************************************************************
// top level of the 8x8 two-pass transform: sequencer, block store and
// the shared multiply-accumulate unit
// *************************************************************************
`timescale 1ns/1ps
`include "idct_config.svh"

module idct (
   input  logic                    clk,
   input  logic                    racc,
   input  logic                    start,
   input  logic                    rapx,
   input  logic [`IDCT_DATA_W-1:0] din,
   output logic                    reading,
   output logic                    done,
   output logic [`IDCT_DATA_W-1:0] dout
);
   import idctPkg::*;

   phaseT phase;
   elemIdxU elemIdx;

   idctMacIf macBus ();

   idctSequencer sequencer (
      .clk     (clk),
      .racc    (racc),
      .start   (start),
      .phase   (phase),
      .elemIdx (elemIdx),
      .reading (reading),
      .done    (done)
   );

   idctBlockStore blockStore (
      .clk     (clk),
      .racc    (racc),
      .rapx    (rapx),
      .phase   (phase),
      .elemIdx (elemIdx),
      .din     (din),
      .mac     (macBus),
      .dout    (dout)
   );

   idctMac macUnit (
      .clk  (clk),
      .racc (racc),
      .mac  (macBus)
   );

endmodule

/* design/idctBlockStore.sv */
// *************************************************************************
// input, intermediate and output blocks, operand selection with the
// approximate-mode cut, and result write-back
// *************************************************************************
`timescale 1ns/1ps
`include "idct_config.svh"

module idctBlockStore (
   input  logic             clk,
   input  logic             racc,
   input  logic             rapx,
   input  idctPkg::phaseT   phase,
   input  idctPkg::elemIdxU elemIdx,
   input  idctPkg::sampleT  din,
   idctMacIf.store          mac,
   output idctPkg::sampleT  dout
);
   import idctPkg::*;

   localparam operandT AllOnes = '1;

   sampleT inBlk  [`IDCT_BLOCK_N][`IDCT_BLOCK_N];
   sampleT tmpBlk [`IDCT_BLOCK_N][`IDCT_BLOCK_N];
   sampleT outBlk [`IDCT_BLOCK_N][`IDCT_BLOCK_N];

   logic [2:0] outer, row, term;
   logic [2:0] romRow;
   logic colPass;
   operandT coef, rawA, maskA, maskB;

   assign outer   = elemIdx.f.outer;
   assign row     = elemIdx.f.row;
   assign term    = elemIdx.f.term;
   assign colPass = phase == ColPass;

   // row pass uses C[outer][term], column pass C[row][term]
   assign romRow = colPass ? row : outer;
   idctCoefRom coefRom (.row(romRow), .col(term), .coef(coef));

   // column pass reads the transposed intermediate, scaled down by 2^8
   assign rawA = colPass ? operandT'(tmpBlk[term][outer][`IDCT_P2_SRC_LSB +: `IDCT_OPND_W])
                         : operandT'(inBlk[row][term][`IDCT_OPND_W-1:0]);

   always_comb
   begin
      maskA = AllOnes;
      maskB = AllOnes;
      if (rapx)
      begin
         maskA = AllOnes << (colPass ? `IDCT_P2_CUT_A : `IDCT_P1_CUT_A);
         maskB = AllOnes << (colPass ? `IDCT_P2_CUT_B : `IDCT_P1_CUT_B);
      end
   end

   assign mac.issue    = colPass || (phase == RowPass);
   assign mac.opA      = rawA & maskA;
   assign mac.opB      = coef & maskB;
   assign mac.colPass  = colPass;
   assign mac.lastTerm = term == 3'd7;
   assign mac.dstIdx   = {row, outer};

   always_ff @(posedge clk)
   begin
      if (phase == Load)
         inBlk[row][term] <= din;
      if (mac.resultValid)
      begin
         if (mac.resultCol)
            outBlk[mac.resultIdx[5:3]][mac.resultIdx[2:0]] <= mac.result;
         else
            tmpBlk[mac.resultIdx[5:3]][mac.resultIdx[2:0]] <= mac.result;
      end
   end

   always_ff @(posedge clk or posedge racc)
   begin
      if (racc)
         dout <= '0;
      else if ((phase == Finish) || (phase == Stream))
         dout <= outBlk[row][term];
   end

endmodule

/* design/idctCoefRom.sv */
// *************************************************************************
// constant 8x8 cosine coefficient table
// *************************************************************************
`timescale 1ns/1ps

module idctCoefRom (
   input  logic [2:0]       row,
   input  logic [2:0]       col,
   output idctPkg::operandT coef
);
   import idctPkg::*;

   // C[u][x] = round(32768 * s(u) * cos((2x+1)u*pi/16))
   // s(0) = sqrt(1/8), s(u) = 1/2 otherwise
   localparam operandT CoefTab [64] = '{
      11585,  11585,  11585,  11585,  11585,  11585,  11585,  11585,
      16069,  13623,   9102,   3196,  -3196,  -9102, -13623, -16069,
      15137,   6270,  -6270, -15137, -15137,  -6270,   6270,  15137,
      13623,  -3196, -16069,  -9102,   9102,  16069,   3196, -13623,
      11585, -11585, -11585,  11585,  11585, -11585, -11585,  11585,
       9102, -16069,   3196,  13623, -13623,  -3196,  16069,  -9102,
       6270, -15137,  15137,  -6270,  -6270,  15137, -15137,   6270,
       3196,  -9102,  13623, -16069,  16069, -13623,   9102,  -3196
   };

   // row selects the frequency, col the sample position
   assign coef = CoefTab[{row, col}];

endmodule

/* design/idctSequencer.sv */
// *************************************************************************
// phase FSM and element counter; generates the reading level and the
// done pulse
// *************************************************************************
`timescale 1ns/1ps
`include "idct_config.svh"

module idctSequencer (
   input  logic             clk,
   input  logic             racc,
   input  logic             start,
   output idctPkg::phaseT   phase,
   output idctPkg::elemIdxU elemIdx,
   output logic             reading,
   output logic             done
);
   import idctPkg::*;

   localparam int FlushW = $clog2(`IDCT_MAC_DEPTH) + 1;
   // 64 elements for load and stream
   localparam int LastElem = `IDCT_BLOCK_N * `IDCT_BLOCK_N - 1;
   // 512 terms per pass
   localparam int LastTerm = `IDCT_BLOCK_N * `IDCT_BLOCK_N * `IDCT_BLOCK_N - 1;

   logic [FlushW-1:0] flushCnt;
   logic passPhase;
   logic counting;
   logic idxEnd;
   logic flushEnd;

   assign passPhase = (phase == RowPass) || (phase == ColPass);
   assign counting  = passPhase || (phase == Load) || (phase == Finish) ||
                      (phase == Stream);
   assign idxEnd    = passPhase ? (elemIdx.lin == 9'(LastTerm))
                                : (elemIdx.lin == 9'(LastElem));
   assign flushEnd  = flushCnt == FlushW'(`IDCT_MAC_DEPTH - 1);

   always_ff @(posedge clk or posedge racc)
   begin
      if (racc)
      begin
         phase    <= Idle;
         elemIdx  <= '0;
         flushCnt <= '0;
      end
      else
      begin
         // the counter wraps to 0, so every phase starts at element 0
         if (counting)
            elemIdx.lin <= idxEnd ? 9'd0 : elemIdx.lin + 9'd1;

         case (phase)
            Idle:
            begin
               if (start)
                  phase <= Load;
            end
            Load:
            begin
               if (idxEnd)
                  phase <= RowPass;
            end
            RowPass:
            begin
               if (idxEnd)
                  phase <= RowFlush;
            end
            ColPass:
            begin
               if (idxEnd)
                  phase <= ColFlush;
            end
            // let the last products drain out of the MAC
            RowFlush, ColFlush:
            begin
               if (flushEnd)
               begin
                  flushCnt <= '0;
                  phase    <= (phase == RowFlush) ? ColPass : Finish;
               end
               else
                  flushCnt <= flushCnt + 1'b1;
            end
            // element 0 leaves on the edge after done
            Finish:
            begin
               phase <= Stream;
            end
            Stream:
            begin
               if (idxEnd)
                  phase <= Idle;
            end
            default:
            begin
               phase <= Idle;
            end
         endcase
      end
   end

   assign reading = phase == Load;
   assign done    = phase == Finish;

endmodule

/* mac/idctMac.sv */
// *************************************************************************
// shared pipelined multiply-accumulate: scaled product register,
// accumulator and the sideband that follows the data
// *************************************************************************
`timescale 1ns/1ps
`include "idct_config.svh"

module idctMac (
   input logic     clk,
   input logic     racc,
   idctMacIf.mac   mac
);
   import idctPkg::*;

   logic signed [2*`IDCT_OPND_W-1:0] fullProd;
   sampleT prodQ, acc;
   logic prodValid, prodLast, prodCol;
   logic [5:0] prodIdx, accIdx;
   logic accValid, accCol, fresh;

   // 24x24 signed, product bits 47:16 kept
   assign fullProd = mac.opA * mac.opB;

   always_ff @(posedge clk or posedge racc)
   begin
      if (racc)
      begin
         prodValid <= 1'b0;
         prodLast  <= 1'b0;
         accValid  <= 1'b0;
         fresh     <= 1'b1;
      end
      else
      begin
         prodValid <= mac.issue;
         prodLast  <= mac.lastTerm;
         accValid  <= prodValid && prodLast;
         // the term after a last term starts a new sum
         if (prodValid)
            fresh <= prodLast;
      end
   end

   always_ff @(posedge clk)
   begin
      prodQ   <= sampleT'(fullProd >>> `IDCT_PROD_SHIFT);
      prodIdx <= mac.dstIdx;
      prodCol <= mac.colPass;
      if (prodValid)
      begin
         acc    <= (fresh ? '0 : acc) + prodQ;
         accIdx <= prodIdx;
         accCol <= prodCol;
      end
   end

   assign mac.resultValid = accValid;
   assign mac.result      = acc;
   assign mac.resultIdx   = accIdx;
   assign mac.resultCol   = accCol;

endmodule

/* run.sh */
#!/bin/sh
# build the transform testbench with Verilator, run it, and check the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f build.f \
   --top-module idctTb -o idctSim --Mdir obj_dir
./obj_dir/idctSim > sim.log 2>&1 || true
cat sim.log

if grep -qx "NO ERRORS" sim.log; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi
